// ==== timer_soc.f ====
+incdir+hw
hw/timer_soc_pkg.sv
hw/bus_decoder.sv
hw/mtimer_slot.sv
hw/resp_mux.sv
hw/timer_soc.sv
tests/tb_timer_soc.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_timer_soc
FILELIST  := timer_soc.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_timer_soc.sv ====
`include "timer_soc_defs.svh"

module tb_timer_soc;
  localparam int n_slots = `TIMER_SOC_N_SLOTS;
  localparam logic [1:0] mode_exact = 2'd0;
  localparam logic [1:0] mode_gt    = 2'd1;
  localparam logic [1:0] mode_same  = 2'd2;
  localparam logic [1:0] mode_none  = 2'd3;
  localparam logic [31:0] ctrl_en   = 32'd1 << `TIMER_SOC_CTRL_EN;

  // one table row, request plus what must come back
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic        exp_err;
    logic [1:0]  mode;
    logic [7:0]  gap;
    logic        irq_chk;
    logic [3:0]  exp_irq;
    logic [2:0]  test;
  } entry_t;

  logic                    clk;
  logic                    rst_n_i;
  timer_soc_pkg::bus_req_t bus_req_i;
  timer_soc_pkg::bus_rsp_t bus_rsp_o;
  logic [n_slots-1:0]      irq_o;

  entry_t      tbl [0:127];
  int          issue_cyc [0:127];
  // table indices of requests still waiting for a response
  int          sb_q [$];
  int          n_ent = 0;
  int          cyc = 0;
  int          limit = 200;
  int          n_checks = 0;
  int          n_errors = 0;
  int          test_errors [1:5];
  string       test_name [1:5] = '{"register readback", "pipelining", "error responses",
                                   "counting", "interrupts"};
  logic [2:0]  cur_test;
  logic [31:0] last_rd;
  integer      seed;

  timer_soc timer_soc_inst (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .irq_o     (irq_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // cycle count and watchdog
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] reg_addr(input int slot, input logic [7:0] off);
    reg_addr = `TIMER_SOC_BASE | (32'(slot) << `TIMER_SOC_SLOT_LSB) | {24'd0, off};
  endfunction

  task automatic check_value(input logic [2:0] test, input string what,
                             input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      test_errors[test]++;
      $display("[ERROR] time %0t: test %0d %s is 32'h%08h, expected 32'h%08h",
               $time, test, what, got, exp);
    end
  endtask

  task automatic add_entry(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp, input logic exp_err, input logic [1:0] mode);
    tbl[n_ent] = '{we, addr, wdata, exp, exp_err, mode, 8'd0, 1'b0, 4'd0, cur_test};
    n_ent++;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data, input logic err);
    add_entry(1'b1, addr, data, 32'd0, err, mode_none);
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp,
                          input logic [1:0] mode, input logic err);
    add_entry(1'b0, addr, 32'd0, exp, err, mode);
  endtask

  // irq levels checked a few idle cycles after the last row
  task automatic expect_irq(input logic [3:0] irq);
    tbl[n_ent-1].gap     = 8'd4;
    tbl[n_ent-1].irq_chk = 1'b1;
    tbl[n_ent-1].exp_irq = irq;
  endtask

  task automatic build_table();
    logic [31:0] cnt_v [0:n_slots-1];
    logic [31:0] cmp_v [0:n_slots-1];
    logic [31:0] val;
    // all slots disabled, random values written then read back
    cur_test = 3'd1;
    for (int s = 0; s < n_slots; s++) begin
      cnt_v[s] = $random(seed);
      cmp_v[s] = $random(seed);
      write_reg(reg_addr(s, `TIMER_SOC_OFF_COUNT), cnt_v[s], 1'b0);
      write_reg(reg_addr(s, `TIMER_SOC_OFF_CMP), cmp_v[s], 1'b0);
    end
    for (int s = 0; s < n_slots; s++) begin
      read_reg(reg_addr(s, `TIMER_SOC_OFF_COUNT), cnt_v[s], mode_exact, 1'b0);
      read_reg(reg_addr(s, `TIMER_SOC_OFF_CMP), cmp_v[s], mode_exact, 1'b0);
    end
    for (int s = 0; s < n_slots; s++) begin
      write_reg(reg_addr(s, `TIMER_SOC_OFF_CTRL), ctrl_en, 1'b0);
      read_reg(reg_addr(s, `TIMER_SOC_OFF_CTRL), ctrl_en, mode_exact, 1'b0);
      write_reg(reg_addr(s, `TIMER_SOC_OFF_CTRL), 32'd0, 1'b0);
      read_reg(reg_addr(s, `TIMER_SOC_OFF_CTRL), 32'd0, mode_exact, 1'b0);
    end
    // back to back, read right after write on alternating slots
    cur_test = 3'd2;
    for (int s = 0; s < n_slots; s++) begin
      val = $random(seed);
      cmp_v[s] = val;
      write_reg(reg_addr(s, `TIMER_SOC_OFF_CMP), val, 1'b0);
      read_reg(reg_addr(s, `TIMER_SOC_OFF_CMP), val, mode_exact, 1'b0);
      val = $random(seed);
      write_reg(reg_addr(n_slots - 1 - s, `TIMER_SOC_OFF_COUNT), val, 1'b0);
      read_reg(reg_addr(n_slots - 1 - s, `TIMER_SOC_OFF_COUNT), val, mode_exact, 1'b0);
    end
    // bad offset, outside region, slot past the end
    // the last two alias slot 0 count if decoded wrongly
    cur_test = 3'd3;
    val = $random(seed);
    write_reg(reg_addr(0, `TIMER_SOC_OFF_COUNT), val, 1'b0);
    write_reg(reg_addr(0, 8'h0C), $random(seed), 1'b1);
    write_reg(32'hE000_0000, ~val, 1'b1);
    write_reg(reg_addr(n_slots, `TIMER_SOC_OFF_COUNT), ~val, 1'b1);
    read_reg(reg_addr(0, 8'h0C), 32'd0, mode_exact, 1'b1);
    read_reg(32'hE000_0000, 32'd0, mode_exact, 1'b1);
    read_reg(reg_addr(n_slots, `TIMER_SOC_OFF_COUNT), 32'd0, mode_exact, 1'b1);
    read_reg(reg_addr(0, `TIMER_SOC_OFF_COUNT), val, mode_exact, 1'b0);
    read_reg(reg_addr(0, `TIMER_SOC_OFF_CMP), cmp_v[0], mode_exact, 1'b0);
    read_reg(reg_addr(0, `TIMER_SOC_OFF_CTRL), 32'd0, mode_exact, 1'b0);
    // slot 1 runs for a while, then frozen
    cur_test = 3'd4;
    write_reg(reg_addr(1, `TIMER_SOC_OFF_COUNT), 32'd100, 1'b0);
    write_reg(reg_addr(1, `TIMER_SOC_OFF_CTRL), ctrl_en, 1'b0);
    tbl[n_ent-1].gap = 8'd10;
    write_reg(reg_addr(1, `TIMER_SOC_OFF_CTRL), 32'd0, 1'b0);
    read_reg(reg_addr(1, `TIMER_SOC_OFF_COUNT), 32'd100, mode_gt, 1'b0);
    read_reg(reg_addr(1, `TIMER_SOC_OFF_COUNT), 32'd0, mode_same, 1'b0);
    read_reg(reg_addr(1, `TIMER_SOC_OFF_COUNT), 32'd0, mode_same, 1'b0);
    // slot 2 irq follows compare and enable
    cur_test = 3'd5;
    write_reg(reg_addr(2, `TIMER_SOC_OFF_COUNT), 32'd1000, 1'b0);
    write_reg(reg_addr(2, `TIMER_SOC_OFF_CMP), 32'd500, 1'b0);
    write_reg(reg_addr(2, `TIMER_SOC_OFF_CTRL), ctrl_en, 1'b0);
    expect_irq(4'b0100);
    write_reg(reg_addr(2, `TIMER_SOC_OFF_CMP), 32'hFFFF_0000, 1'b0);
    expect_irq(4'b0000);
    write_reg(reg_addr(2, `TIMER_SOC_OFF_CMP), 32'd0, 1'b0);
    expect_irq(4'b0100);
    write_reg(reg_addr(2, `TIMER_SOC_OFF_CTRL), 32'd0, 1'b0);
    expect_irq(4'b0000);
    limit = n_ent * 4 + 200;
  endtask

  task automatic drive_req(input int idx);
    @(posedge clk);
    #2;
    bus_req_i = '{1'b1, tbl[idx].we, tbl[idx].addr, tbl[idx].wdata};
    issue_cyc[idx] = cyc;
    sb_q.push_back(idx);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    bus_req_i = '0;
  endtask

  task automatic check_response(input int idx);
    entry_t e;
    e = tbl[idx];
    check_value(e.test, "latency", 32'(cyc - issue_cyc[idx]), 32'd2);
    check_value(e.test, "err", {31'd0, bus_rsp_o.err}, {31'd0, e.exp_err});
    // writes and errors always carry zero data
    if (e.we || e.exp_err) begin
      check_value(e.test, "rdata", bus_rsp_o.rdata, 32'd0);
    end else begin
      case (e.mode)
        mode_exact: check_value(e.test, "rdata", bus_rsp_o.rdata, e.exp);
        mode_gt:    check_value(e.test, "count advanced", {31'd0, bus_rsp_o.rdata > e.exp}, 32'd1);
        mode_same:  check_value(e.test, "repeat read", bus_rsp_o.rdata, last_rd);
        default:    ;
      endcase
      last_rd = bus_rsp_o.rdata;
    end
  endtask

  // responses are stable mid-cycle
  always @(negedge clk) begin : monitor
    int idx;
    if (rst_n_i) begin
      if (bus_rsp_o.valid === 1'b1) begin
        if (sb_q.size() == 0) begin
          n_errors++;
          $display("time %0t: response arrived with no request outstanding", $time);
        end else begin
          idx = sb_q.pop_front();
          check_response(idx);
        end
      end
      if (sb_q.size() > 0 && cyc > issue_cyc[sb_q[0]] + 2) begin
        idx = sb_q.pop_front();
        n_errors++;
        test_errors[tbl[idx].test]++;
        $display("test %0d: request from cycle %0d never got a response",
                 tbl[idx].test, issue_cyc[idx]);
      end
    end
  end

  task automatic finish_test(input logic [2:0] t);
    idle_cycle();
    while (sb_q.size() > 0) begin
      idle_cycle();
    end
    $display("test %0d %s: %0d errors", t, test_name[t], test_errors[t]);
  endtask

  initial begin : main
    seed = 32'hc92;
    rst_n_i = 1'b0;
    bus_req_i = '0;
    last_rd = '0;
    for (int t = 1; t <= 5; t++) begin
      test_errors[t] = 0;
    end
    build_table();
    repeat (5) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    for (int i = 0; i < n_ent; i++) begin
      drive_req(i);
      repeat (int'(tbl[i].gap)) idle_cycle();
      if (tbl[i].irq_chk) begin
        check_value(tbl[i].test, "irq", 32'(irq_o), 32'(tbl[i].exp_irq));
      end
      if (i == n_ent - 1 || tbl[i + 1].test != tbl[i].test) begin
        finish_test(tbl[i].test);
      end
    end
    $display("summary: 5 tests, %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== hw/timer_soc.sv ====
`include "timer_soc_defs.svh"

module timer_soc (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  timer_soc_pkg::bus_req_t       bus_req_i,
  output timer_soc_pkg::bus_rsp_t       bus_rsp_o,
  output logic [`TIMER_SOC_N_SLOTS-1:0] irq_o
);
  // request lanes, one per slot
  timer_soc_pkg::slot_req_t [`TIMER_SOC_N_SLOTS-1:0] slot_req;
  // per slot responses into the mux
  timer_soc_pkg::bus_rsp_t  [`TIMER_SOC_N_SLOTS-1:0] slot_rsp;
  // unmapped address strobe
  logic                                              dec_err;

  // first stage, address decode
  bus_decoder u_bus_decoder (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .bus_req_i  (bus_req_i),
    .slot_req_o (slot_req),
    .dec_err_o  (dec_err)
  );

  // second stage, identical timer slots
  for (genvar i = 0; i < `TIMER_SOC_N_SLOTS; i++) begin : g_slot
    mtimer_slot u_mtimer_slot (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .slot_req_i (slot_req[i]),
      .slot_rsp_o (slot_rsp[i]),
      .irq_o      (irq_o[i])
    );
  end

  // responses back to the master
  resp_mux u_resp_mux (
    .clk        (clk),
    .slot_rsp_i (slot_rsp),
    .dec_err_i  (dec_err),
    .bus_rsp_o  (bus_rsp_o)
  );

endmodule

// ==== hw/resp_mux.sv ====
`include "timer_soc_defs.svh"

module resp_mux (
  // only samples the source check below
  input  logic                                             clk,
  input  timer_soc_pkg::bus_rsp_t [`TIMER_SOC_N_SLOTS-1:0] slot_rsp_i,
  input  logic                                             dec_err_i,
  output timer_soc_pkg::bus_rsp_t                          bus_rsp_o
);
  logic [`TIMER_SOC_N_SLOTS:0] src_vld;
  logic                        any_vld;
  logic                        any_err;
  timer_soc_pkg::data_t        mux_rdata;

  // active sources, decode error on top
  always_comb begin
    for (int i = 0; i < `TIMER_SOC_N_SLOTS; i++) begin
      src_vld[i] = slot_rsp_i[i].valid;
    end
    src_vld[`TIMER_SOC_N_SLOTS] = dec_err_i;
  end

  // and-or merge
  // at most one source is active in a cycle
  always_comb begin
    any_vld   = dec_err_i;
    any_err   = dec_err_i;
    mux_rdata = '0;
    for (int i = 0; i < `TIMER_SOC_N_SLOTS; i++) begin
      if (slot_rsp_i[i].valid) begin
        any_vld   = 1'b1;
        any_err   = any_err | slot_rsp_i[i].err;
        mux_rdata = mux_rdata | slot_rsp_i[i].rdata;
      end
    end
  end

  // decode error carries zero data
  always_comb begin
    bus_rsp_o.valid = any_vld;
    bus_rsp_o.err   = any_err;
    bus_rsp_o.rdata = mux_rdata;
  end

  // decoder sends one lane per request, slots answer in one cycle
  // so two responses can never collide here
  assert property (@(posedge clk)
    !$isunknown(src_vld) |-> $onehot0(src_vld));

endmodule

// ==== hw/mtimer_slot.sv ====
`include "timer_soc_defs.svh"

module mtimer_slot (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  timer_soc_pkg::slot_req_t slot_req_i,
  output timer_soc_pkg::bus_rsp_t  slot_rsp_o,
  output logic                     irq_o
);
  timer_soc_pkg::data_t count_q;
  timer_soc_pkg::data_t cmp_q;
  logic                 en_q;
  timer_soc_pkg::data_t count_d;
  timer_soc_pkg::data_t cmp_d;
  logic                 en_d;
  logic                 irq_q;
  logic                 hit_count;
  logic                 hit_cmp;
  logic                 hit_ctrl;
  logic                 bad_off;
  logic                 wr_count;
  logic                 wr_cmp;
  logic                 wr_ctrl;
  timer_soc_pkg::data_t rd_data;
  logic                 rsp_valid_q;
  logic                 rsp_err_q;
  timer_soc_pkg::data_t rsp_rdata_q;

  // offset decode
  always_comb begin
    hit_count = slot_req_i.offset == `TIMER_SOC_OFF_COUNT;
    hit_cmp   = slot_req_i.offset == `TIMER_SOC_OFF_CMP;
    hit_ctrl  = slot_req_i.offset == `TIMER_SOC_OFF_CTRL;
    bad_off   = !(hit_count || hit_cmp || hit_ctrl);
    wr_count  = slot_req_i.valid && slot_req_i.we && hit_count;
    wr_cmp    = slot_req_i.valid && slot_req_i.we && hit_cmp;
    wr_ctrl   = slot_req_i.valid && slot_req_i.we && hit_ctrl;
  end

  // next state, a count write beats the increment
  always_comb begin
    count_d = count_q;
    if (wr_count) begin
      count_d = slot_req_i.wdata;
    end else if (en_q) begin
      count_d = count_q + 32'd1;
    end
    cmp_d = wr_cmp ? slot_req_i.wdata : cmp_q;
    en_d  = wr_ctrl ? slot_req_i.wdata[`TIMER_SOC_CTRL_EN] : en_q;
  end

  // read mux sees values before this edge
  always_comb begin
    case (slot_req_i.offset)
      `TIMER_SOC_OFF_COUNT: rd_data = count_q;
      `TIMER_SOC_OFF_CMP:   rd_data = cmp_q;
      `TIMER_SOC_OFF_CTRL:  rd_data = {31'd0, en_q};
      default:              rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count_q     <= '0;
      cmp_q       <= '0;
      en_q        <= 1'b0;
      irq_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      count_q     <= count_d;
      cmp_q       <= cmp_d;
      en_q        <= en_d;
      // irq tracks the registers it is built from
      irq_q       <= en_d && (count_d >= cmp_d);
      rsp_valid_q <= slot_req_i.valid;
    end
  end

  // response payload, zero data on writes and errors
  always_ff @(posedge clk) begin
    if (slot_req_i.valid) begin
      rsp_err_q   <= bad_off;
      rsp_rdata_q <= (slot_req_i.we || bad_off) ? '0 : rd_data;
    end
  end

  always_comb begin
    slot_rsp_o.valid = rsp_valid_q;
    slot_rsp_o.err   = rsp_err_q;
    slot_rsp_o.rdata = rsp_rdata_q;
  end

  assign irq_o = irq_q;

  // no interrupt from a disabled timer
  assert property (@(posedge clk) disable iff (!rst_n_i) irq_o |-> en_q);

endmodule

// ==== hw/bus_decoder.sv ====
`include "timer_soc_defs.svh"

module bus_decoder (
  input  logic                                               clk,
  input  logic                                               rst_n_i,
  input  timer_soc_pkg::bus_req_t                            bus_req_i,
  output timer_soc_pkg::slot_req_t [`TIMER_SOC_N_SLOTS-1:0]  slot_req_o,
  output logic                                               dec_err_o
);
  localparam timer_soc_pkg::addr_t base_addr = `TIMER_SOC_BASE;
  localparam int idx_w = `TIMER_SOC_REGION_LSB - `TIMER_SOC_SLOT_LSB;

  logic                      in_region;
  logic                      slot_ok;
  logic [idx_w-1:0]          slot_idx;
  timer_soc_pkg::slot_sel_t  slot_sel;
  timer_soc_pkg::slot_sel_t  lane_vld_q;
  logic                      err_q;
  logic                      err_dly_q;
  logic                      we_q;
  timer_soc_pkg::offset_t    offset_q;
  timer_soc_pkg::data_t      wdata_q;

  // region match plus slot index range check
  always_comb begin
    in_region = bus_req_i.addr[31:`TIMER_SOC_REGION_LSB] ==
                base_addr[31:`TIMER_SOC_REGION_LSB];
    slot_idx  = bus_req_i.addr[`TIMER_SOC_SLOT_LSB +: idx_w];
    slot_ok   = in_region && (int'(slot_idx) < `TIMER_SOC_N_SLOTS);
    slot_sel  = '0;
    for (int i = 0; i < `TIMER_SOC_N_SLOTS; i++) begin
      slot_sel[i] = slot_ok && (int'(slot_idx) == i);
    end
  end

  // lane strobes and error strobe
  // error held one more cycle so it lines up with slot responses
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lane_vld_q <= '0;
      err_q      <= 1'b0;
      err_dly_q  <= 1'b0;
    end else begin
      lane_vld_q <= bus_req_i.valid ? slot_sel : '0;
      err_q      <= bus_req_i.valid && !slot_ok;
      err_dly_q  <= err_q;
    end
  end

  // payload shared by every lane
  always_ff @(posedge clk) begin
    if (bus_req_i.valid) begin
      we_q     <= bus_req_i.we;
      offset_q <= bus_req_i.addr[`TIMER_SOC_SLOT_LSB-1:0];
      wdata_q  <= bus_req_i.wdata;
    end
  end

  always_comb begin
    for (int i = 0; i < `TIMER_SOC_N_SLOTS; i++) begin
      slot_req_o[i].valid  = lane_vld_q[i];
      slot_req_o[i].we     = we_q;
      slot_req_o[i].offset = offset_q;
      slot_req_o[i].wdata  = wdata_q;
    end
  end

  assign dec_err_o = err_dly_q;

  // at most one lane, never lane and error together
  assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0({lane_vld_q, err_q}));

endmodule

// ==== hw/timer_soc_pkg.sv ====
`include "timer_soc_defs.svh"

package timer_soc_pkg;

  // bus address, one word
  typedef logic [31:0] addr_t;

  // bus data word
  typedef logic [31:0] data_t;

  // register offset within one slot
  typedef logic [7:0] offset_t;

  // one-hot slot select
  typedef logic [`TIMER_SOC_N_SLOTS-1:0] slot_sel_t;

  // request from the master, valid is a one-cycle strobe
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // response to the master, also used per slot
  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  // request lane into a single slot
  typedef struct packed {
    logic    valid;
    logic    we;
    offset_t offset;
    data_t   wdata;
  } slot_req_t;

endpackage

// ==== hw/timer_soc_defs.svh ====
`ifndef TIMER_SOC_DEFS_SVH
`define TIMER_SOC_DEFS_SVH

// number of timer slots behind the decoder
`define TIMER_SOC_N_SLOTS 4

// region base, bits above REGION_LSB must match
`define TIMER_SOC_BASE 32'hF000_0000
`define TIMER_SOC_REGION_LSB 12

// 256 bytes per slot, slot index sits above this bit
`define TIMER_SOC_SLOT_LSB 8

// register offsets inside one slot
`define TIMER_SOC_OFF_COUNT 8'h00
`define TIMER_SOC_OFF_CMP 8'h04
`define TIMER_SOC_OFF_CTRL 8'h08

// ctrl bit positions
`define TIMER_SOC_CTRL_EN 0

`endif
